// ==== logic/mulPipePkg.sv ====
/*
   shared widths, step counts and sequencer states of the multiply pipeline
   the step counts are tied to the operand width and the digit width, so
   changing one of them alone breaks the multiplier
*/
`default_nettype none

package mulPipePkg;

   // ******************************
   // data widths
   // ******************************

   // one word on dataIn; a pair is two of these on consecutive cycles
   typedef logic [15:0] operandT;
   // full 16 x 16 product, unsigned
   typedef logic [31:0] productT;
   // the running sum wraps at 40 bits and nothing flags it
   typedef logic [39:0] sumT;

   // ******************************
   // multiplier step counts
   // ******************************

   // multiplier bits retired per cycle (radix 16)
   localparam int digitWidth = 4;
   // 16 multiplier bits take four digits
   localparam int fullSteps = 4;
   // short mode only looks at the low byte of the second word
   localparam int shortSteps = 2;
   // the step counter must also hold the terminal value fullSteps
   localparam int stepWidth = $clog2(fullSteps + 1);
   typedef logic [stepWidth-1:0] stepT;

   // ******************************
   // master sequencer states
   // ******************************
   typedef enum logic [3:0] {
      idle,
      fullLoad, fullIssue, fullMul1, fullMul2, fullMul3, fullDrain,
      shortLoad, shortIssue, shortWait, shortDrain, shortReissue, shortFlush
   } masterStateT;

endpackage

`default_nettype wire

// ==== logic/pipeMaster.sv ====
/*
   master sequencer that starts the load, multiply and result stages
   threeOnly is only looked at while idle; a change during a run is ignored
   there is no handshake, a firstDataInRdy pulse in a busy state is dropped
*/
`timescale 1ns/1ps
`default_nettype none

module pipeMaster (
   input  wire  Clock,
   input  wire  rstN,
   input  wire  threeOnly,
   input  wire  firstDataInRdy,
   output logic startLoad,
   output logic startMul,
   output logic startResult,
   output logic shortOp
);

   import mulPipePkg::*;

   masterStateT state;
   masterStateT nextState;

   // ******************************
   // state register
   // ******************************
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         state <= idle;
      end else begin
         state <= nextState;
      end
   end

   // ******************************
   // next state and start strobes
   // ******************************

   // strobes are combinational from the state and the request, so startLoad
   // lands in the same cycle as the first word on dataIn
   always_comb begin
      nextState   = state;
      startLoad   = 1'b0;
      startMul    = 1'b0;
      startResult = 1'b0;
      case (state)
         idle: begin
            // the mode is fixed here for the whole run that follows
            if (firstDataInRdy) begin
               startLoad = 1'b1;
               nextState = threeOnly ? shortLoad : fullLoad;
            end
         end
         // full path, one pair every six cycles
         fullLoad: begin
            // second word is being captured by the loader
            nextState = fullIssue;
         end
         fullIssue: begin
            startMul  = 1'b1;
            nextState = fullMul1;
         end
         fullMul1: nextState = fullMul2;
         fullMul2: nextState = fullMul3;
         fullMul3: nextState = fullDrain;
         fullDrain: begin
            // the product is final here, and a new pair may start at once
            startResult = 1'b1;
            if (firstDataInRdy) begin
               startLoad = 1'b1;
               nextState = fullLoad;
            end else begin
               nextState = idle;
            end
         end
         // short path, loads overlap the previous multiply
         shortLoad: nextState = shortIssue;
         shortIssue: begin
            startMul  = 1'b1;
            nextState = shortWait;
         end
         shortWait: begin
            // decision point: chain another pair or flush the last product
            if (firstDataInRdy) begin
               startLoad = 1'b1;
               nextState = shortDrain;
            end else begin
               nextState = shortFlush;
            end
         end
         shortDrain: begin
            // the previous product is taken while the new B word loads
            startResult = 1'b1;
            nextState   = shortReissue;
         end
         shortReissue: begin
            startMul  = 1'b1;
            nextState = shortWait;
         end
         shortFlush: begin
            startResult = 1'b1;
            nextState   = idle;
         end
         default: nextState = idle;
      endcase
   end

   // ******************************
   // mode flag for the multiplier
   // ******************************

   // only sampled by the multiplier together with startMul
   always_comb begin
      case (state)
         shortLoad, shortIssue, shortWait,
         shortDrain, shortReissue, shortFlush: shortOp = 1'b1;
         default:                               shortOp = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/operandLoader.sv ====
/*
   captures the two words of an operand pair from dataIn
   word A comes with startLoad and word B must follow on the very next cycle
   both words hold until the next startLoad
*/
`timescale 1ns/1ps
`default_nettype none

module operandLoader (
   input  wire               Clock,
   input  wire               rstN,
   input  wire               startLoad,
   input  mulPipePkg::operandT dataIn,
   output mulPipePkg::operandT opA,
   output mulPipePkg::operandT opB
);

   // set for one cycle after startLoad, while word B is on dataIn
   logic secondDue;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         secondDue <= 1'b0;
      end else begin
         secondDue <= startLoad;
      end
   end

   // operand registers carry payload only
   always_ff @(posedge Clock) begin
      if (startLoad) begin
         opA <= dataIn;
      end
      // B is valid from the cycle after this edge onwards
      if (secondDue) begin
         opB <= dataIn;
      end
   end

endmodule

`default_nettype wire

// ==== logic/shiftAddMultiplier.sv ====
/*
   unsigned iterative multiplier, four multiplier bits per cycle
   the first digit is added on the startMul edge itself, so the product
   register is final fullSteps or shortSteps cycles after startMul
   short mode drops the upper byte of opB; product holds until the next start
*/
`timescale 1ns/1ps
`default_nettype none

module shiftAddMultiplier (
   input  wire                 Clock,
   input  wire                 rstN,
   input  wire                 startMul,
   input  wire                 shortOp,
   input  mulPipePkg::operandT opA,
   input  mulPipePkg::operandT opB,
   output mulPipePkg::productT product
);

   import mulPipePkg::*;

   // local copies, the loader may already take the next pair
   operandT mcand;
   operandT mplier;
   stepT    stepCnt;
   stepT    stepLimit;

   operandT                curA;
   logic [digitWidth-1:0]  curDigit;
   logic [1:0]             curShift;
   productT                term;

   // ******************************
   // one partial product per cycle
   // ******************************

   // on the start edge the term comes straight from the loader outputs,
   // afterwards from the latched copies at the current digit position
   always_comb begin
      if (startMul) begin
         curA     = opA;
         curDigit = opB[digitWidth-1:0];
         curShift = 2'd0;
      end else begin
         curA     = mcand;
         curShift = stepCnt[1:0];
         curDigit = mplier[digitWidth * curShift +: digitWidth];
      end
      term = (productT'(curA) * productT'(curDigit)) << (digitWidth * curShift);
   end

   // ******************************
   // step control
   // ******************************

   // idle when the counter has reached the limit for the current mode
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         stepCnt   <= stepT'(fullSteps);
         stepLimit <= stepT'(fullSteps);
      end else if (startMul) begin
         stepCnt   <= stepT'(1);
         stepLimit <= shortOp ? stepT'(shortSteps) : stepT'(fullSteps);
      end else if (stepCnt != stepLimit) begin
         stepCnt <= stepCnt + stepT'(1);
      end
   end

   // ******************************
   // datapath
   // ******************************
   always_ff @(posedge Clock) begin
      if (startMul) begin
         mcand   <= opA;
         // short mode multiplies by the low byte only
         mplier  <= shortOp ? {8'h00, opB[7:0]} : opB;
         // partial sum restarts from the first digit term
         product <= term;
      end else if (stepCnt != stepLimit) begin
         product <= product + term;
      end
   end

endmodule

`default_nettype wire

// ==== logic/resultAccumulator.sv ====
/*
   adds each finished product into a running 40-bit sum
   only reset clears the sum, and it wraps silently on overflow
   resultValid is high for the one cycle after startResult
*/
`timescale 1ns/1ps
`default_nettype none

module resultAccumulator (
   input  wire                 Clock,
   input  wire                 rstN,
   input  wire                 startResult,
   input  mulPipePkg::productT product,
   output mulPipePkg::sumT     resultOut,
   output logic                resultValid
);

   import mulPipePkg::*;

   // ******************************
   // running sum
   // ******************************

   // product is unsigned, so zero extension is enough
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         resultOut <= '0;
      end else if (startResult) begin
         resultOut <= resultOut + sumT'(product);
      end
   end

   // ******************************
   // output strobe
   // ******************************

   // the new sum is visible in the same cycle this goes high
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         resultValid <= 1'b0;
      end else begin
         resultValid <= startResult;
      end
   end

endmodule

`default_nettype wire

// ==== logic/mulPipeTop.sv ====
/*
   multiply pipeline top level, sequencer plus three stages
   inTaken marks each accepted first word; B must follow on the next cycle
   results are single-cycle pulses with no back-pressure
*/
`timescale 1ns/1ps
`default_nettype none

module mulPipeTop (
   input  wire                 Clock,
   input  wire                 rstN,
   input  wire                 threeOnly,
   input  wire                 firstDataInRdy,
   input  mulPipePkg::operandT dataIn,
   output logic                inTaken,
   output mulPipePkg::sumT     resultOut,
   output logic                resultValid
);

   import mulPipePkg::*;

   // stage start strobes from the master
   logic startMul;
   logic startResult;
   logic shortOp;

   // datapath between the stages
   operandT opA;
   operandT opB;
   productT product;

   // ******************************
   // sequencer
   // ******************************

   // the load strobe doubles as the accepted-request output
   pipeMaster master (
      .Clock          (Clock),
      .rstN           (rstN),
      .threeOnly      (threeOnly),
      .firstDataInRdy (firstDataInRdy),
      .startLoad      (inTaken),
      .startMul       (startMul),
      .startResult    (startResult),
      .shortOp        (shortOp)
   );

   // ******************************
   // stages
   // ******************************
   operandLoader loader (
      .Clock     (Clock),
      .rstN      (rstN),
      .startLoad (inTaken),
      .dataIn    (dataIn),
      .opA       (opA),
      .opB       (opB)
   );

   shiftAddMultiplier multiplier (
      .Clock    (Clock),
      .rstN     (rstN),
      .startMul (startMul),
      .shortOp  (shortOp),
      .opA      (opA),
      .opB      (opB),
      .product  (product)
   );

   resultAccumulator accumulator (
      .Clock       (Clock),
      .rstN        (rstN),
      .startResult (startResult),
      .product     (product),
      .resultOut   (resultOut),
      .resultValid (resultValid)
   );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
/*
   free-running 100 ns clock for the testbench
   rstN starts low and is released by the 16th rising edge
*/
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic Clock,
   output logic rstN
);

   localparam int halfPeriod  = 50;
   localparam int resetCycles = 16;

   initial begin
      Clock = 1'b0;
      forever begin
         #halfPeriod Clock = ~Clock;
      end
   end

   // released on a rising edge, like every other synchronous input
   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge Clock);
      rstN <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== verification/mulPipe_checker.sv ====
/*
   port timing assertions for the multiply pipeline, bound into mulPipeTop
   threeOnly is taken as the mode of each accepted pair, which only holds
   while the environment changes it with the pipeline idle
*/
`timescale 1ns/1ps
`default_nettype none

module mulPipeChecker (
   input wire Clock,
   input wire rstN,
   input wire threeOnly,
   input wire firstDataInRdy,
   input wire inTaken,
   input wire resultValid
);

   // counts every failing assertion, the testbench watches it
   int failCount = 0;

   // ******************************
   // reset and request acceptance
   // ******************************
   noResultAfterReset: assert property (@(posedge Clock) !rstN |=> !resultValid)
      else begin failCount++; $error("resultValid high right after a reset cycle"); end
   takeNeedsRequest: assert property (@(posedge Clock) disable iff (!rstN)
      inTaken |-> firstDataInRdy)
      else begin failCount++; $error("inTaken without firstDataInRdy"); end

   // ******************************
   // latency from inTaken
   // ******************************

   // full pairs finish 7 cycles after acceptance, short pairs after 5
   fullLatency: assert property (@(posedge Clock) disable iff (!rstN)
      $past(inTaken, 7) && !$past(threeOnly, 7) |-> resultValid)
      else begin failCount++; $error("full-mode result missing 7 cycles after inTaken"); end
   shortLatency: assert property (@(posedge Clock) disable iff (!rstN)
      $past(inTaken, 5) && $past(threeOnly, 5) |-> resultValid)
      else begin failCount++; $error("short-mode result missing 5 cycles after inTaken"); end
   // a result pulse with no accepted pair behind it means a dropped request leaked
   resultHasSource: assert property (@(posedge Clock) disable iff (!rstN)
      resultValid |-> ($past(inTaken, 7) && !$past(threeOnly, 7)) ||
                      ($past(inTaken, 5) && $past(threeOnly, 5)))
      else begin failCount++; $error("resultValid without a matching inTaken"); end

   // ******************************
   // request spacing
   // ******************************
   fullSpacing: assert property (@(posedge Clock) disable iff (!rstN)
      inTaken && !threeOnly |-> !$past(inTaken, 1) && !$past(inTaken, 2) &&
                                !$past(inTaken, 3) && !$past(inTaken, 4) && !$past(inTaken, 5))
      else begin failCount++; $error("full-mode inTaken closer than 6 cycles"); end
   shortSpacing: assert property (@(posedge Clock) disable iff (!rstN)
      inTaken && threeOnly |-> !$past(inTaken, 1) && !$past(inTaken, 2))
      else begin failCount++; $error("short-mode inTaken closer than 3 cycles"); end
   // in short mode a waiting request is taken exactly 3 cycles after the last one
   shortChain: assert property (@(posedge Clock) disable iff (!rstN)
      $past(inTaken, 3) && $past(threeOnly, 3) && firstDataInRdy |-> inTaken)
      else begin failCount++; $error("short-mode request not chained after 3 cycles"); end

endmodule

bind mulPipeTop mulPipeChecker timingCheck (
   .Clock          (Clock),
   .rstN           (rstN),
   .threeOnly      (threeOnly),
   .firstDataInRdy (firstDataInRdy),
   .inTaken        (inTaken),
   .resultValid    (resultValid)
);

`default_nettype wire

// ==== verification/mulPipeTb.sv ====
/*
   random operand pairs in both modes against a running-sum model
   threeOnly only changes after 8 quiet cycles, so the mode seen with an
   accepted pair is the mode the DUT runs it in
   port timing is checked by the bound checker, the sums are checked here
*/
`timescale 1ns/1ps
`default_nettype none

module mulPipeTb;

   import mulPipePkg::*;

   localparam int pairCount     = 300;
   localparam int timeoutCycles = pairCount * 12 + 200;
   localparam int seed          = 37095;

   logic    Clock;
   logic    rstN;
   logic    threeOnly;
   logic    firstDataInRdy;
   operandT dataIn;
   logic    inTaken;
   sumT     resultOut;
   logic    resultValid;

   // accepted pairs still waiting for their result, oldest first
   logic    modeQ[$];
   operandT aQ[$];
   operandT bQ[$];

   logic    bWordDue    = 1'b0;
   logic    pendMode    = 1'b0;
   operandT pendA       = '0;
   sumT     modelSum    = '0;
   int      takenCount  = 0;
   int      resultCount = 0;
   int      cycleCount  = 0;

   clockGen clocks (
      .Clock (Clock),
      .rstN  (rstN)
   );

   mulPipeTop DUT (
      .Clock          (Clock),
      .rstN           (rstN),
      .threeOnly      (threeOnly),
      .firstDataInRdy (firstDataInRdy),
      .dataIn         (dataIn),
      .inTaken        (inTaken),
      .resultOut      (resultOut),
      .resultValid    (resultValid)
   );

   task automatic stopWithFailure();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   // short mode multiplies by the low byte of B only
   function automatic productT modeProduct(input logic shortMode, input operandT a,
                                           input operandT b);
      productT mult;
      mult = shortMode ? productT'(b[7:0]) : productT'(b);
      return productT'(a) * mult;
   endfunction

   // corner values now and then, otherwise mostly large or fully random words
   function automatic operandT pickOperand();
      int unsigned kind;
      operandT     word;
      kind = $urandom % 8;
      if (kind == 0) word = 16'h0000;
      else if (kind == 1) word = 16'hFFFF;
      else if (kind < 4) word = 16'hF000 | operandT'($urandom % 4096);
      else word = operandT'($urandom);
      return word;
   endfunction

   // raises the request with A, then sends B in the cycle after acceptance
   task automatic offerPair(input operandT a, input operandT b, input bit persist,
                            output bit taken);
      bit seen;
      seen = 1'b0;
      firstDataInRdy <= 1'b1;
      dataIn         <= a;
      do begin
         @(negedge Clock);
         seen = inTaken;
         @(posedge Clock);
      end while (!seen && persist);
      firstDataInRdy <= 1'b0;
      if (seen) begin
         dataIn <= b;
         @(posedge Clock);
      end
      taken = seen;
   endtask

   // ******************************
   // model and sum check
   // ******************************
   always @(negedge Clock) begin : pairMonitor
      logic    modeNow;
      operandT aNow;
      operandT bNow;
      if (rstN) begin
         if (bWordDue) begin
            modeQ.push_back(pendMode);
            aQ.push_back(pendA);
            bQ.push_back(dataIn);
         end
         bWordDue = inTaken;
         if (inTaken) begin
            pendMode = threeOnly;
            pendA    = dataIn;
            takenCount++;
         end
         if (resultValid) begin
            if (aQ.size() == 0) begin
               $display("result pulse at %0d ns with no accepted pair waiting", $time);
               stopWithFailure();
            end else begin
               modeNow  = modeQ.pop_front();
               aNow     = aQ.pop_front();
               bNow     = bQ.pop_front();
               // the model sum wraps at 40 bits by its type alone
               modelSum = modelSum + sumT'(modeProduct(modeNow, aNow, bNow));
               resultCount++;
               assert (resultOut == modelSum) else begin
                  $display("** Error at %0d ns: resultOut %h, expected %h (A %h B %h short %b)",
                           $time, resultOut, modelSum, aNow, bNow, modeNow);
                  stopWithFailure();
               end
            end
         end
      end
   end

   always @(negedge Clock) begin
      if (DUT.timingCheck.failCount != 0) begin
         $display("a port timing assertion failed at %0d ns", $time);
         stopWithFailure();
      end
   end

   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount > timeoutCycles) begin
         $display("timeout: the run did not end within %0d cycles", timeoutCycles);
         stopWithFailure();
      end
   end

   // ******************************
   // stimulus
   // ******************************
   initial begin : stimulus
      bit          taken;
      int unsigned gap;
      int          pairs;
      void'($urandom(seed));
      threeOnly      = 1'b0;
      firstDataInRdy = 1'b0;
      dataIn         = '0;
      pairs          = 0;
      @(posedge rstN);
      @(posedge Clock);
      while (pairs < pairCount) begin
         // the master samples the mode only in idle, so let it drain first
         if ($urandom % 16 == 0) begin
            repeat (8) @(posedge Clock);
            threeOnly <= ($urandom % 2) != 0;
         end
         // a lone one-cycle request usually lands in a busy state and is dropped
         if ($urandom % 5 == 0) begin
            offerPair(pickOperand(), pickOperand(), 1'b0, taken);
         end else begin
            offerPair(pickOperand(), pickOperand(), 1'b1, taken);
         end
         if (taken) pairs++;
         gap = $urandom % 3;
         repeat (gap) begin
            dataIn <= operandT'($urandom);
            @(posedge Clock);
         end
      end
      while (resultCount < takenCount) @(posedge Clock);
      // a stray late pulse would still show up in these cycles
      repeat (10) @(posedge Clock);
      if (resultCount == takenCount && aQ.size() == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("%0d results for %0d accepted pairs", resultCount, takenCount);
         stopWithFailure();
      end
   end

endmodule

`default_nettype wire

// ==== mulPipeTop.f ====
logic/mulPipePkg.sv
logic/pipeMaster.sv
logic/operandLoader.sv
logic/shiftAddMultiplier.sv
logic/resultAccumulator.sv
logic/mulPipeTop.sv
verification/clockGen.sv
verification/mulPipe_checker.sv
verification/mulPipeTb.sv

// ==== Makefile ====
# Verilator build and run of the multiply pipeline testbench

.PHONY: all run lint clean

all: run

obj_dir/VmulPipeTb: mulPipeTop.f logic/*.sv verification/*.sv
	verilator --binary --timing --assert -f mulPipeTop.f --top-module mulPipeTb

# the result is decided by the pass line in the log, not by the exit code
run: obj_dir/VmulPipeTb
	obj_dir/VmulPipeTb +verilator+error+limit+100 | tee sim.log
	grep -q '^>>> PASS$$' sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f mulPipeTop.f --top-module mulPipeTb

clean:
	rm -rf obj_dir sim.log
